//--- design/uart_line_pkg.sv
package uart_line_pkg;

	localparam int BAUD_DIV_W = 8;  // bit time is baud_div+1 cycles

	typedef enum logic [1:0] {DL5 = 2'd0, DL6 = 2'd1, DL7 = 2'd2, DL8 = 2'd3} data_len_e;
	typedef enum logic [1:0] {SL1 = 2'd0, SL2 = 2'd1} stop_len_e;  // codes 2 and 3 act as SL2
	typedef enum logic [1:0] {PAR_ODD, PAR_EVEN, PAR_MARK, PAR_SPACE} parity_e;

	// frame FSM states, same sequence for both directions
	typedef enum logic [2:0] {IDLE, START, DATA, PARITY, STOP} line_state_e;

	function automatic logic [2:0] last_data_bit(data_len_e dl);
		return 3'd4 + 3'(dl);
	endfunction

	function automatic logic parity_bit(logic [7:0] data, data_len_e dl, parity_e pt);
		logic [7:0] mask;
		logic x;
		mask = 8'hff >> (2'd3 - 2'(dl));  // only bits on the line
		x = ^(data & mask);
		case (pt)
			PAR_ODD: return ~x;
			PAR_EVEN: return x;
			PAR_MARK: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

endpackage

//--- design/uart_reg_pkg.sv
package uart_reg_pkg;

	localparam int ADDR_W = 6;  // word address bits

	typedef enum logic [1:0] {
		REG_STATUS = 2'd0,
		REG_LEVEL = 2'd1,
		REG_MODE = 2'd2,
		REG_DATA = 2'd3
	} reg_addr_e;

	localparam int FIFO_AW = 4;  // 16 entries each way
	localparam int RX_IRQ_LEVEL = 12;
	localparam int RX_IDLE_CYCLES = 2000;
	localparam int IDLE_CNT_W = $clog2(RX_IDLE_CYCLES);

	// mode register fields
	localparam int MODE_DIV_LSB = 8;
	localparam int MODE_DL_LSB = 6;
	localparam int MODE_SL_LSB = 4;
	localparam int MODE_PAR_EN = 3;
	localparam int MODE_PAR_LSB = 1;
	localparam int MODE_EN = 0;

	localparam int ST_TX_EMPTY = 0;
	localparam int ST_RX_NOT_EMPTY = 1;
	localparam int ST_TX_OVERFLOW = 2;
	localparam int ST_RX_UNDERFLOW = 3;
	localparam int ST_RX_OVERFLOW = 4;
	localparam int ST_FRAME_ERROR = 5;
	localparam int ST_TX_ACTIVE = 30;
	localparam int ST_RX_BUSY = 31;

	localparam int LVL_RX_LSB = 16;  // rx count in upper half, tx free space in lower

endpackage

//--- design/uart_fifo.sv
`timescale 1ns/1ps

module uart_fifo #(
	parameter int AW = 4
) (
	input logic clk,
	input logic rst,
	input logic clr_i,
	input logic push_i,
	input logic [7:0] wdata_i,
	input logic pop_i,
	output logic [7:0] rdata_o,
	output logic full_o,
	output logic empty_o,
	output logic [AW:0] count_o
);

	logic [7:0] mem [2**AW];
	logic [AW:0] wr_ptr;  // extra bit tells full from empty
	logic [AW:0] rd_ptr;
	logic do_push;
	logic do_pop;

	assign do_push = push_i && !full_o;
	assign do_pop = pop_i && !empty_o;

	always_ff @(posedge clk) begin
		if (rst || clr_i) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr[AW-1:0]] <= wdata_i;
	end

	// head is visible without a pop
	assign rdata_o = mem[rd_ptr[AW-1:0]];

	assign count_o = wr_ptr - rd_ptr;
	assign full_o = count_o[AW];
	assign empty_o = (count_o == '0);

endmodule

//--- design/uart_tx.sv
`timescale 1ns/1ps

module uart_tx
	import uart_line_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic [BAUD_DIV_W-1:0] baud_div_i,
	input data_len_e data_len_i,
	input stop_len_e stop_len_i,
	input logic par_en_i,
	input parity_e par_type_i,
	input logic en_i,
	input logic [7:0] data_i,
	output logic ack_o,
	output logic busy_o,
	output logic tx_o
);

	line_state_e state;
	logic [BAUD_DIV_W-1:0] bit_cnt;  // cycles into current bit
	logic [2:0] bit_idx;
	logic stop_two;  // second stop bit running
	logic [7:0] shreg;
	logic par_bit;
	logic bit_end;

	assign bit_end = (bit_cnt == baud_div_i);
	assign ack_o = (state == IDLE) && en_i;  // byte taken on this edge
	assign busy_o = (state != IDLE);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
			bit_cnt <= '0;
			bit_idx <= '0;
			stop_two <= 1'b0;
		end else begin
			bit_cnt <= (state == IDLE || bit_end) ? '0 : bit_cnt + 1'b1;
			case (state)
				IDLE: begin
					if (en_i)
						state <= START;
				end
				START: begin
					if (bit_end) begin
						state <= DATA;
						bit_idx <= '0;
					end
				end
				DATA: begin
					if (bit_end) begin
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == last_data_bit(data_len_i))
							state <= par_en_i ? PARITY : STOP;
					end
				end
				PARITY: begin
					if (bit_end)
						state <= STOP;
				end
				default: begin
					if (bit_end) begin
						if (stop_len_i == SL1 || stop_two) begin
							state <= IDLE;
							stop_two <= 1'b0;
						end else begin
							stop_two <= 1'b1;
						end
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (ack_o) begin
			shreg <= data_i;
			par_bit <= parity_bit(data_i, data_len_i, par_type_i);
		end else if (state == DATA && bit_end) begin
			shreg <= shreg >> 1;  // lsb first
		end
	end

	always_comb begin
		case (state)
			START: tx_o = 1'b0;
			DATA: tx_o = shreg[0];
			PARITY: tx_o = par_bit;
			default: tx_o = 1'b1;  // idle and stop level
		endcase
	end

endmodule

//--- design/uart_rx.sv
`timescale 1ns/1ps

module uart_rx
	import uart_line_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic [BAUD_DIV_W-1:0] baud_div_i,
	input data_len_e data_len_i,
	input stop_len_e stop_len_i,
	input logic par_en_i,
	input parity_e par_type_i,
	input logic en_i,
	input logic rx_i,
	output logic [7:0] data_o,
	output logic valid_o,
	output logic err_o,
	output logic busy_o
);

	logic rx_s1;
	logic rx_s2;
	logic rx_prev;  // for falling edge
	line_state_e state;
	logic [BAUD_DIV_W-1:0] bit_cnt;
	logic [2:0] bit_idx;
	logic stop_two;
	logic frame_bad;  // parity or first stop bit wrong
	logic [7:0] shreg;
	logic sample;
	logic half_bit;
	logic last_stop;

	assign sample = (bit_cnt == baud_div_i);
	assign half_bit = (bit_cnt == (baud_div_i >> 1));
	assign last_stop = (stop_len_i == SL1) || stop_two;
	assign data_o = shreg;
	assign busy_o = (state != IDLE);

	always_ff @(posedge clk) begin
		if (rst) begin
			rx_s1 <= 1'b1;
			rx_s2 <= 1'b1;
			rx_prev <= 1'b1;
		end else begin
			rx_s1 <= rx_i;
			rx_s2 <= rx_s1;
			rx_prev <= rx_s2;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
			bit_cnt <= '0;
			bit_idx <= '0;
			stop_two <= 1'b0;
			frame_bad <= 1'b0;
			valid_o <= 1'b0;
			err_o <= 1'b0;
		end else begin
			valid_o <= 1'b0;
			err_o <= 1'b0;
			bit_cnt <= (state == IDLE || sample) ? '0 : bit_cnt + 1'b1;
			case (state)
				IDLE: begin
					if (en_i && rx_prev && !rx_s2)
						state <= START;
				end
				START: begin
					if (half_bit) begin  // recheck start at its middle
						bit_cnt <= '0;
						bit_idx <= '0;
						stop_two <= 1'b0;
						frame_bad <= 1'b0;
						state <= rx_s2 ? IDLE : DATA;
					end
				end
				DATA: begin
					if (sample) begin
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == last_data_bit(data_len_i))
							state <= par_en_i ? PARITY : STOP;
					end
				end
				PARITY: begin
					if (sample) begin
						if (rx_s2 != parity_bit(shreg, data_len_i, par_type_i))
							frame_bad <= 1'b1;
						state <= STOP;
					end
				end
				default: begin
					// frame ends at the middle of the last stop bit
					if (sample) begin
						if (last_stop) begin
							state <= IDLE;
							err_o <= frame_bad || !rx_s2;
							valid_o <= !frame_bad && rx_s2;
						end else begin
							stop_two <= 1'b1;
							if (!rx_s2)
								frame_bad <= 1'b1;
						end
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == START && half_bit)
			shreg <= '0;  // unused upper bits stay zero
		else if (state == DATA && sample)
			shreg[bit_idx] <= rx_s2;
	end

endmodule

//--- design/wb_uart.sv
`timescale 1ns/1ps

module wb_uart
	import uart_line_pkg::*;
	import uart_reg_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic rx_i,
	output logic tx_o,
	input logic wbs_cs_i,
	input logic [ADDR_W-1:0] wbs_addr_i,
	input logic [3:0] wbs_sel_i,
	input logic [31:0] wbs_data_i,
	input logic wbs_we_i,
	output logic [31:0] wbs_data_o,
	output logic wbs_ack_o,
	output logic irq_o
);

	logic [31:0] reg_mode;
	data_len_e mode_dl;
	stop_len_e mode_sl;
	parity_e mode_pt;
	logic accept;
	logic addr_ok;
	reg_addr_e reg_sel;
	logic mode_wr;
	logic data_wr;
	logic data_rd;
	logic [31:0] rd_word;
	logic [31:0] status;
	logic [31:0] level;
	logic tx_en;
	logic tx_ack;
	logic tx_busy;
	logic [7:0] tx_data;
	logic tx_full;
	logic tx_empty;
	logic [FIFO_AW:0] tx_count;
	logic [FIFO_AW:0] tx_free;
	logic [7:0] rx_data;
	logic rx_valid;
	logic rx_err;
	logic rx_busy;
	logic [7:0] rx_head;
	logic rx_full;
	logic rx_empty;
	logic [FIFO_AW:0] rx_count;
	logic tx_of;
	logic rx_of;
	logic rx_uf;
	logic frame_err;
	logic tx_empty_q;
	logic [FIFO_AW:0] rx_count_q;
	logic [IDLE_CNT_W-1:0] idle_cnt;
	logic irq_event;

	assign mode_dl = data_len_e'(reg_mode[MODE_DL_LSB +: 2]);
	assign mode_sl = stop_len_e'(reg_mode[MODE_SL_LSB +: 2]);
	assign mode_pt = parity_e'(reg_mode[MODE_PAR_LSB +: 2]);

	// one transfer per cs, ack must fall before the next
	assign accept = wbs_cs_i && !wbs_ack_o;
	assign addr_ok = (wbs_addr_i[ADDR_W-1:2] == '0);
	assign reg_sel = reg_addr_e'(wbs_addr_i[1:0]);
	assign mode_wr = accept && addr_ok && reg_sel == REG_MODE && wbs_we_i;
	assign data_wr = accept && addr_ok && reg_sel == REG_DATA && wbs_we_i;
	assign data_rd = accept && addr_ok && reg_sel == REG_DATA && !wbs_we_i;

	assign tx_en = reg_mode[MODE_EN] && !tx_empty;
	assign tx_free = (FIFO_AW+1)'(2**FIFO_AW) - tx_count;

	uart_tx u_tx (
		.clk(clk),
		.rst(rst),
		.baud_div_i(reg_mode[MODE_DIV_LSB +: BAUD_DIV_W]),
		.data_len_i(mode_dl),
		.stop_len_i(mode_sl),
		.par_en_i(reg_mode[MODE_PAR_EN]),
		.par_type_i(mode_pt),
		.en_i(tx_en),
		.data_i(tx_data),
		.ack_o(tx_ack),
		.busy_o(tx_busy),
		.tx_o(tx_o)
	);

	uart_rx u_rx (
		.clk(clk),
		.rst(rst),
		.baud_div_i(reg_mode[MODE_DIV_LSB +: BAUD_DIV_W]),
		.data_len_i(mode_dl),
		.stop_len_i(mode_sl),
		.par_en_i(reg_mode[MODE_PAR_EN]),
		.par_type_i(mode_pt),
		.en_i(reg_mode[MODE_EN]),
		.rx_i(rx_i),
		.data_o(rx_data),
		.valid_o(rx_valid),
		.err_o(rx_err),
		.busy_o(rx_busy)
	);

	uart_fifo #(.AW(FIFO_AW)) tx_fifo (
		.clk(clk),
		.rst(rst),
		.clr_i(mode_wr),
		.push_i(data_wr),
		.wdata_i(wbs_data_i[7:0]),  // sel ignored for data
		.pop_i(tx_ack),
		.rdata_o(tx_data),
		.full_o(tx_full),
		.empty_o(tx_empty),
		.count_o(tx_count)
	);

	uart_fifo #(.AW(FIFO_AW)) rx_fifo (
		.clk(clk),
		.rst(rst),
		.clr_i(mode_wr),
		.push_i(rx_valid),
		.wdata_i(rx_data),
		.pop_i(data_rd),
		.rdata_o(rx_head),
		.full_o(rx_full),
		.empty_o(rx_empty),
		.count_o(rx_count)
	);

	always_comb begin
		status = '0;
		status[ST_TX_EMPTY] = tx_empty;
		status[ST_RX_NOT_EMPTY] = !rx_empty;
		status[ST_TX_OVERFLOW] = tx_of;
		status[ST_RX_UNDERFLOW] = rx_uf;
		status[ST_RX_OVERFLOW] = rx_of;
		status[ST_FRAME_ERROR] = frame_err;
		status[ST_TX_ACTIVE] = tx_busy;
		status[ST_RX_BUSY] = rx_busy;
		level = '0;
		level[LVL_RX_LSB +: FIFO_AW+1] = rx_count;
		level[0 +: FIFO_AW+1] = tx_free;
	end

	always_comb begin
		rd_word = '0;  // unmapped words read zero
		if (addr_ok) begin
			case (reg_sel)
				REG_STATUS: rd_word = status;
				REG_LEVEL: rd_word = level;
				REG_MODE: rd_word = reg_mode;
				default: rd_word = rx_empty ? '0 : {24'b0, rx_head};
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			reg_mode <= '0;
			wbs_ack_o <= 1'b0;
		end else begin
			wbs_ack_o <= accept;
			if (mode_wr) begin
				for (int i = 0; i < 4; i++) begin
					if (wbs_sel_i[i])
						reg_mode[8*i +: 8] <= wbs_data_i[8*i +: 8];
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		wbs_data_o <= accept ? rd_word : '0;
	end

	// sticky flags, cleared by any mode write
	always_ff @(posedge clk) begin
		if (rst || mode_wr) begin
			tx_of <= 1'b0;
			rx_of <= 1'b0;
			rx_uf <= 1'b0;
			frame_err <= 1'b0;
		end else begin
			if (data_wr && tx_full)
				tx_of <= 1'b1;
			if (rx_valid && rx_full)
				rx_of <= 1'b1;
			if (data_rd && rx_empty)
				rx_uf <= 1'b1;
			if (rx_err)
				frame_err <= 1'b1;
		end
	end

	// idle time of unread rx data
	always_ff @(posedge clk) begin
		if (rst || rx_empty || data_rd)
			idle_cnt <= '0;
		else if (idle_cnt == IDLE_CNT_W'(RX_IDLE_CYCLES-1))
			idle_cnt <= '0;
		else
			idle_cnt <= idle_cnt + 1'b1;
	end

	assign irq_event = (tx_empty && !tx_empty_q)
		|| (rx_count == (FIFO_AW+1)'(RX_IRQ_LEVEL)
			&& rx_count_q == (FIFO_AW+1)'(RX_IRQ_LEVEL-1))
		|| rx_err
		|| (idle_cnt == IDLE_CNT_W'(RX_IDLE_CYCLES-1))
		|| (data_wr && tx_full)
		|| (rx_valid && rx_full)
		|| (data_rd && rx_empty);

	always_ff @(posedge clk) begin
		if (rst) begin
			tx_empty_q <= 1'b1;
			rx_count_q <= '0;
			irq_o <= 1'b0;
		end else begin
			tx_empty_q <= tx_empty;
			rx_count_q <= rx_count;
			irq_o <= irq_event;
		end
	end

endmodule

//--- verif/wb_uart_checker.sv
`timescale 1ns/1ps

module wb_uart_checker
	import uart_line_pkg::*;
	import uart_reg_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic rx_i,
	input logic tx_o,
	input logic wbs_cs_i,
	input logic [ADDR_W-1:0] wbs_addr_i,
	input logic [3:0] wbs_sel_i,
	input logic [31:0] wbs_data_i,
	input logic wbs_we_i,
	input logic [31:0] wbs_data_o,
	input logic wbs_ack_o,
	input logic irq_o,
	output int error_count
);

	logic [31:0] mode;
	logic [7:0] txq[$];  // written, not yet started
	logic [7:0] rxq[$];
	logic tx_of;
	logic rx_uf;
	logic rx_of;
	logic ferr;
	int irq_count;
	int irq_mark;

	task automatic fail(input string msg);
		error_count++;
		$display("FAILED at %0t ns: %s", $time, msg);
	endtask

	// even parity bit makes the count of ones even
	function automatic logic exp_parity(logic [7:0] d, logic [1:0] dl, logic [1:0] pt);
		logic ones;
		ones = 1'b0;
		for (int i = 0; i < 5 + dl; i++)
			ones ^= d[i];
		case (pt)
			2'd0: return ~ones;
			2'd1: return ones;
			2'd2: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	function automatic logic line_level(bit is_rx);
		return is_rx ? rx_i : tx_o;
	endfunction

	task automatic mark_irq();
		irq_mark = irq_count;
	endtask

	task automatic expect_irq(input string what);
		if (irq_count == irq_mark)
			fail({what, ": no interrupt pulse seen"});
		irq_mark = irq_count;
	endtask

	task automatic expect_no_irq(input string what);
		if (irq_count != irq_mark)
			fail({what, ": interrupt pulse came too early"});
		irq_mark = irq_count;
	endtask

	// decodes frames on one line with the programmed format
	task automatic watch_line(input bit is_rx);
		logic prev;
		logic cur;
		logic ok;
		logic [7:0] d;
		logic [7:0] want;
		logic [7:0] mask;
		logic [31:0] m;
		int t;
		int n;
		prev = 1'b1;
		forever begin
			@(negedge clk);
			cur = line_level(is_rx);
			if (!rst && mode[0] && prev && !cur) begin
				m = mode;
				t = m[15:8] + 1;
				n = 5 + m[7:6];
				mask = 8'((1 << n) - 1);
				ok = 1'b1;
				d = '0;
				want = '0;
				if (!is_rx) begin
					if (txq.size() == 0)
						fail("frame on tx_o while the TX FIFO was empty");
					else
						want = txq.pop_front();
				end
				repeat (t / 2) @(negedge clk);  // middle of start bit
				for (int i = 0; i < n; i++) begin
					repeat (t) @(negedge clk);
					d[i] = line_level(is_rx);
				end
				if (m[3]) begin
					repeat (t) @(negedge clk);
					if (line_level(is_rx) != exp_parity(d, m[7:6], m[2:1]))
						ok = 1'b0;
				end
				for (int s = 0; s < (m[5:4] == 2'd0 ? 1 : 2); s++) begin
					repeat (t) @(negedge clk);
					if (!line_level(is_rx))
						ok = 1'b0;
				end
				cur = 1'b1;
				if (is_rx) begin
					if (!ok)
						ferr = 1'b1;
					else if (rxq.size() == 16)
						rx_of = 1'b1;
					else
						rxq.push_back(d);
				end else if (!ok || d !== (want & mask)) begin
					fail($sformatf("tx_o frame %h ok=%0b, expected %h", d, ok, want & mask));
				end
			end
			prev = cur;
		end
	endtask

	initial watch_line(1'b0);
	initial watch_line(1'b1);

	initial begin
		irq_count = 0;
		forever begin
			@(negedge clk);
			if (!rst && irq_o)
				irq_count++;
		end
	end

	// bus side, accept seen half a cycle before the DUT edge
	initial begin
		logic pend;
		logic exp_rd;
		logic [31:0] exp_word;
		logic [31:0] exp_mask;
		error_count = 0;
		irq_mark = 0;
		pend = 1'b0;
		forever begin
			@(negedge clk);
			if (rst) begin
				mode = '0;
				txq.delete();
				rxq.delete();
				{tx_of, rx_uf, rx_of, ferr} = '0;
				pend = 1'b0;
			end else begin
				if (pend) begin
					pend = 1'b0;
					if (!wbs_ack_o)
						fail("bus transfer got no ack");
					else if (exp_rd && (wbs_data_o & exp_mask) !== exp_word)
						fail($sformatf("read addr %0d gave %h, expected %h",
							wbs_addr_i, wbs_data_o & exp_mask, exp_word));
				end else if (wbs_ack_o) begin
					fail("ack without a bus transfer");
				end
				if (wbs_cs_i && !wbs_ack_o) begin
					pend = 1'b1;
					exp_rd = !wbs_we_i;
					exp_word = '0;
					exp_mask = '1;
					if (wbs_addr_i[ADDR_W-1:2] == '0) begin
						case (wbs_addr_i[1:0])
							2'd0: begin
								exp_mask = 32'h3fff_ffff;  // busy bits not modelled
								exp_word = {26'b0, ferr, rx_of, rx_uf, tx_of,
									rxq.size() != 0, txq.size() == 0};
							end
							2'd1: exp_word = (rxq.size() << 16) | (16 - txq.size());
							2'd2: begin
								exp_word = mode;
								if (wbs_we_i) begin
									for (int i = 0; i < 4; i++)
										if (wbs_sel_i[i])
											mode[8*i +: 8] = wbs_data_i[8*i +: 8];
									txq.delete();
									rxq.delete();
									{tx_of, rx_uf, rx_of, ferr} = '0;
								end
							end
							default: begin
								if (wbs_we_i) begin
									if (txq.size() == 16)
										tx_of = 1'b1;
									else
										txq.push_back(wbs_data_i[7:0]);
								end else if (rxq.size() == 0) begin
									rx_uf = 1'b1;
								end else begin
									exp_word = {24'b0, rxq.pop_front()};
								end
							end
						endcase
					end
				end
			end
		end
	end

endmodule

//--- verif/wb_uart_tb.sv
`timescale 1ns/1ps

module wb_uart_tb
	import uart_line_pkg::*;
	import uart_reg_pkg::*;
();

	localparam int FRAME_CYC_MAX = 8 * 12;  // slowest bit time, longest frame
	localparam int NUM_FRAMES = 40;
	localparam int WATCHDOG_CYC = 3 * NUM_FRAMES * FRAME_CYC_MAX + RX_IDLE_CYCLES + 4000;

	logic clk;
	logic rst;
	logic loop;
	logic rx_drv;
	logic rx;
	logic tx;
	logic cs;
	logic [ADDR_W-1:0] addr;
	logic [3:0] sel;
	logic [31:0] wdata;
	logic we;
	logic [31:0] rdata;
	logic ack;
	logic irq;
	int chk_errors;
	int tb_errors;
	int seed;
	int fails;
	int err_mark;
	logic [31:0] cur_mode;
	logic [31:0] rd;

	assign rx = loop ? tx : rx_drv;  // loopback or driven frames

	wb_uart DUT (
		.clk(clk), .rst(rst), .rx_i(rx), .tx_o(tx),
		.wbs_cs_i(cs), .wbs_addr_i(addr), .wbs_sel_i(sel), .wbs_data_i(wdata),
		.wbs_we_i(we), .wbs_data_o(rdata), .wbs_ack_o(ack), .irq_o(irq)
	);

	wb_uart_checker chk (
		.clk(clk), .rst(rst), .rx_i(rx), .tx_o(tx),
		.wbs_cs_i(cs), .wbs_addr_i(addr), .wbs_sel_i(sel), .wbs_data_i(wdata),
		.wbs_we_i(we), .wbs_data_o(rdata), .wbs_ack_o(ack), .irq_o(irq),
		.error_count(chk_errors)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial begin
		repeat (WATCHDOG_CYC) @(posedge clk);
		$display("watchdog expired, the tests did not finish in time");
		$display("TEST FAILED");
		$finish;
	end

	function automatic int rand_below(int n);
		return $unsigned($random(seed)) % n;
	endfunction

	task automatic bus_xfer(input logic [5:0] a, input logic [31:0] d, input logic [3:0] s,
			input logic w, output logic [31:0] q);
		int n;
		cs = 1'b1;
		addr = a;
		wdata = d;
		sel = s;
		we = w;
		n = 0;
		do begin
			@(posedge clk);
			#1;
			n++;
		end while (!ack && n < 20);
		if (!ack) begin
			tb_errors++;
			$display("bus transfer to address %0d never got an ack", a);
		end
		q = rdata;
		cs = 1'b0;
		@(posedge clk);
		#1;  // ack is low again
	endtask

	task automatic bus_write(input logic [5:0] a, input logic [31:0] d, input logic [3:0] s);
		logic [31:0] q;
		bus_xfer(a, d, s, 1'b1, q);
	endtask

	task automatic bus_read(input logic [5:0] a, output logic [31:0] q);
		bus_xfer(a, $random(seed), 4'hf, 1'b0, q);
	endtask

	task automatic set_mode(input int div, input int dl, input int sl, input int pe,
			input int pt, input int en);
		cur_mode = {16'h0, 8'(div), 2'(dl), 2'(sl), 1'(pe), 2'(pt), 1'(en)};
		bus_write(2, cur_mode, 4'hf);
	endtask

	// waits for a quiet tx_o longer than any frame
	task automatic wait_line_idle();
		int quiet;
		int n;
		int t;
		t = cur_mode[15:8] + 1;
		quiet = 0;
		n = 0;
		while (quiet < 13 * t + 4 && n < 4000) begin
			@(negedge clk);
			n++;
			quiet = tx ? quiet + 1 : 0;
		end
		if (n >= 4000) begin
			tb_errors++;
			$display("tx_o never went idle");
		end
		@(posedge clk);
		#1;
	endtask

	task automatic send_frame(input logic [7:0] d, input bit bad_par);
		int t;
		t = cur_mode[15:8] + 1;
		rx_drv = 1'b0;
		repeat (t) @(posedge clk);
		#1;
		for (int i = 0; i < 5 + cur_mode[7:6]; i++) begin
			rx_drv = d[i];
			repeat (t) @(posedge clk);
			#1;
		end
		if (cur_mode[3]) begin
			rx_drv = chk.exp_parity(d, cur_mode[7:6], cur_mode[2:1]) ^ bad_par;
			repeat (t) @(posedge clk);
			#1;
		end
		rx_drv = 1'b1;
		repeat (4 * t) @(posedge clk);  // stop bits and some idle
		#1;
	endtask

	task automatic report_test(input string name);
		int errs;
		errs = chk_errors + tb_errors - err_mark;
		if (errs == 0) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: %0d errors", name, errs);
			fails++;
		end
		err_mark = chk_errors + tb_errors;
	endtask

	initial begin
		int k;
		seed = 32'h5d98;
		{rst, loop, rx_drv, cs, we} = 5'b11100;
		addr = '0;
		sel = '0;
		wdata = '0;
		tb_errors = 0;
		fails = 0;
		err_mark = 0;
		cur_mode = '0;
		repeat (4) @(posedge clk);
		#1 rst = 1'b0;

		for (int i = 0; i < 8; i++) begin
			bus_read(3, rd);  // empty rx read sets a sticky flag
			bus_write(2, $random(seed), 4'(rand_below(16)));
			bus_read(2, rd);
			bus_read(0, rd);
			bus_read(1, rd);
			bus_read(6'(4 + rand_below(60)), rd);
		end
		report_test("mode registers");

		for (int f = 0; f < 4; f++) begin
			set_mode(3 + rand_below(5), rand_below(4), rand_below(4), rand_below(2),
				rand_below(4), 1);
			k = 3 + rand_below(3);
			for (int j = 0; j < k; j++)
				bus_write(3, $random(seed), 4'(rand_below(16)));
			wait_line_idle();
			bus_read(1, rd);
			for (int j = 0; j < k; j++)
				bus_read(3, rd);
		end
		report_test("loopback");

		set_mode(4, 3, 0, 1, 1, 1);
		for (int j = 0; j < 3; j++)
			bus_write(3, $random(seed), 4'hf);
		bus_read(1, rd);
		wait_line_idle();
		bus_read(1, rd);
		for (int j = 0; j < 3; j++)
			bus_read(3, rd);
		bus_read(1, rd);
		report_test("levels");

		loop = 1'b0;
		set_mode(5, 3, 0, 1, 1, 1);
		repeat (2) @(posedge clk);
		#1;
		chk.mark_irq();
		send_frame(8'($random(seed)), 1'b1);
		chk.expect_irq("bad parity");
		bus_read(0, rd);
		bus_read(1, rd);
		send_frame(8'($random(seed)), 1'b0);
		bus_read(3, rd);
		loop = 1'b1;
		report_test("bad parity");

		set_mode(3, 3, 0, 0, 0, 0);
		repeat (2) @(posedge clk);
		#1;
		chk.mark_irq();
		for (int j = 0; j < 17; j++)
			bus_write(3, $random(seed), 4'hf);
		repeat (2) @(posedge clk);
		#1;
		chk.expect_irq("tx overflow");
		bus_read(0, rd);
		bus_read(3, rd);
		repeat (2) @(posedge clk);
		#1;
		chk.expect_irq("rx underflow");
		bus_read(0, rd);
		report_test("overflow and underflow");

		set_mode(3, 3, 0, 0, 0, 1);
		bus_write(3, $random(seed), 4'hf);
		wait_line_idle();
		chk.mark_irq();
		repeat (RX_IDLE_CYCLES - 200) @(posedge clk);
		chk.expect_no_irq("rx timeout window");
		repeat (300) @(posedge clk);
		#1;
		chk.expect_irq("rx timeout");
		bus_read(3, rd);
		set_mode(3, 3, 0, 0, 0, 1);
		for (int j = 0; j < RX_IRQ_LEVEL - 1; j++)
			bus_write(3, $random(seed), 4'hf);
		wait_line_idle();
		bus_write(3, $random(seed), 4'hf);
		repeat (5) @(posedge clk);
		chk.mark_irq();
		wait_line_idle();
		chk.expect_irq("rx level");
		bus_read(1, rd);
		report_test("rx interrupts");

		$display("tests: 6, failed: %0d, errors: %0d", fails, chk_errors + tb_errors);
		if (fails == 0 && chk_errors + tb_errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

//--- wb_uart.f
design/uart_line_pkg.sv
design/uart_reg_pkg.sv
design/uart_fifo.sv
design/uart_tx.sv
design/uart_rx.sv
design/wb_uart.sv
verif/wb_uart_checker.sv
verif/wb_uart_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS = --binary --timing -j 0 -Wno-fatal
TOP = wb_uart_tb
FILELIST = wb_uart.f
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help  - list these targets"
	@echo "  test  - build and run the testbench, result taken from $(LOG)"
	@echo "  clean - remove build output and log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
